// File: include/uart_config.svh
////////////////////////////////////////////////////////////////////////////
// Frame and bus constants shared by RTL and testbench
// Frame is fixed at 8N1 plus one parity bit; stop length is informative
// Register offsets are byte addresses, low two bits ignored by the slave
////////////////////////////////////////////////////////////////////////////

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`define UART_DATA_BITS  8                      // One byte per frame
`define UART_STOP_BITS  1                      // Fixed, transmitter assumes one
// Start, data, parity and stop
`define UART_FRAME_BITS (1 + `UART_DATA_BITS + 1 + `UART_STOP_BITS)

`define UART_AXI_ADDR_W 4                      // Four word registers
`define UART_AXI_DATA_W 32

`define UART_REG_CTRL   4'h0                   // parity_odd, loopback
`define UART_REG_TXDATA 4'h4                   // Write only
`define UART_REG_RXDATA 4'h8                   // Read clears rx_valid
`define UART_REG_STATUS 4'hC                   // W1C on error bits

`endif

// File: hw/uart_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the UART subsystem
// Register enum values follow the byte offsets in the config header
////////////////////////////////////////////////////////////////////////////

`include "uart_config.svh"

package uart_pkg;

    // Transmitter FSM, one-hot style encoding
    typedef enum logic [1:0] {
        TX_IDLE = 2'b01,                        // Line held high
        TX_SEND = 2'b10                         // Shifting out the frame
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE = 2'b01,                        // Waiting for a low sample
        RX_RECV = 2'b10                         // Data, parity, stop
    } rx_state_t;

    // Word address of each register
    typedef enum logic [1:0] {
        REG_CTRL   = 2'(`UART_REG_CTRL >> 2),
        REG_TXDATA = 2'(`UART_REG_TXDATA >> 2),
        REG_RXDATA = 2'(`UART_REG_RXDATA >> 2),
        REG_STATUS = 2'(`UART_REG_STATUS >> 2)
    } reg_addr_t;

endpackage

// File: hw/uart_tx.sv
////////////////////////////////////////////////////////////////////////////
// UART serializer, one bit per baud_clk cycle
// Frame is start, 8 data LSB first, parity, stop
// start_tx is honoured only in idle; the register block gates it
////////////////////////////////////////////////////////////////////////////

`include "uart_config.svh"

module uart_tx (
    input  logic                       baud_clk,
    input  logic                       reset,
    input  logic [`UART_DATA_BITS-1:0] tx_data,    // Byte to send
    input  logic                       start_tx,   // One-cycle request
    input  logic                       parity_odd, // 0 even, 1 odd
    output logic                       tx,         // Serial line
    output logic                       tx_busy     // High for the whole frame
);

    localparam int FRAME = `UART_FRAME_BITS;
    localparam int CNT_W = $clog2(FRAME);

    uart_pkg::tx_state_t  state;
    logic [FRAME-1:0]     shreg;               // Bit 0 is on the line
    logic [CNT_W-1:0]     bit_cnt;             // Index of bit on the line
    logic                 parity;

    // Even parity from XOR, flipped for odd
    assign parity = (^tx_data) ^ parity_odd;
    assign tx     = shreg[0];

    always_ff @(posedge baud_clk) begin
        if (reset) begin
            state   <= uart_pkg::TX_IDLE;
            tx_busy <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '1;                      // Idle line is high
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (start_tx) begin
                        // Stop, parity, data, start
                        shreg   <= {{`UART_STOP_BITS{1'b1}}, parity, tx_data, 1'b0};
                        bit_cnt <= '0;          // Start bit goes out now
                        tx_busy <= 1'b1;
                        state   <= uart_pkg::TX_SEND;
                    end
                end

                uart_pkg::TX_SEND: begin
                    shreg <= {1'b1, shreg[FRAME-1:1]}; // Refill with idle ones
                    if (bit_cnt == CNT_W'(FRAME - 1)) begin
                        // Stop bit just finished
                        tx_busy <= 1'b0;
                        state   <= uart_pkg::TX_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                default: begin
                    state   <= uart_pkg::TX_IDLE; // Recover from bad encoding
                    tx_busy <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hw/uart_rx.sv
////////////////////////////////////////////////////////////////////////////
// UART deserializer taking one sample per baud_clk cycle
// No oversampling; rx must be synchronous to baud_clk
// Error flags are meaningful only while rx_done is high
////////////////////////////////////////////////////////////////////////////

`include "uart_config.svh"

module uart_rx (
    input  logic                       baud_clk,
    input  logic                       reset,
    input  logic                       rx,            // Serial line
    input  logic                       parity_odd,    // 0 even, 1 odd
    output logic [`UART_DATA_BITS-1:0] rx_data,       // Last received byte
    output logic                       rx_done,       // One-cycle pulse
    output logic                       rx_parity_err, // Parity mismatch
    output logic                       rx_frame_err   // Stop bit was low
);

    localparam int DBITS = `UART_DATA_BITS;
    localparam int CNT_W = $clog2(`UART_FRAME_BITS);

    uart_pkg::rx_state_t  state;
    logic [CNT_W-1:0]     bit_cnt;             // Samples taken after start
    logic [DBITS-1:0]     shreg;
    logic                 par_bit;             // Captured parity bit
    logic                 data_phase;
    logic                 par_phase;
    logic                 stop_phase;

    // Sample classification while receiving
    assign data_phase = (state == uart_pkg::RX_RECV) && (bit_cnt < CNT_W'(DBITS));
    assign par_phase  = (state == uart_pkg::RX_RECV) && (bit_cnt == CNT_W'(DBITS));
    assign stop_phase = (state == uart_pkg::RX_RECV) && (bit_cnt == CNT_W'(DBITS + 1));

    assign rx_data = shreg;

    // Control
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            state   <= uart_pkg::RX_IDLE;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;                    // Pulse by default low
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (!rx) begin              // Start bit seen
                        bit_cnt <= '0;
                        state   <= uart_pkg::RX_RECV;
                    end
                end

                uart_pkg::RX_RECV: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (stop_phase) begin
                        rx_done <= 1'b1;        // Lands cycle after stop sample
                        state   <= uart_pkg::RX_IDLE;
                    end
                end

                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Data shift and frame checks
    always_ff @(posedge baud_clk) begin
        if (data_phase) begin
            shreg <= {rx, shreg[DBITS-1:1]};    // LSB arrives first
        end
        if (par_phase) begin
            par_bit <= rx;
        end
        if (stop_phase) begin
            // Expected parity is the data XOR flipped for odd
            rx_parity_err <= par_bit ^ (^shreg) ^ parity_odd;
            rx_frame_err  <= ~rx;
        end
    end

endmodule

// File: hw/uart_regs.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite register slave for the UART
// One outstanding write and one outstanding read; responses always OKAY
// wstrb is ignored, full words are written
////////////////////////////////////////////////////////////////////////////

`include "uart_config.svh"

module uart_regs (
    input  logic                         baud_clk,
    input  logic                         reset,
    // AXI write
    input  logic [`UART_AXI_ADDR_W-1:0]  axi_awaddr,
    input  logic                         axi_awvalid,
    output logic                         axi_awready,
    input  logic [`UART_AXI_DATA_W-1:0]  axi_wdata,
    input  logic [`UART_AXI_DATA_W/8-1:0] axi_wstrb,  // Ignored
    input  logic                         axi_wvalid,
    output logic                         axi_wready,
    output logic [1:0]                   axi_bresp,
    output logic                         axi_bvalid,
    input  logic                         axi_bready,
    // AXI read
    input  logic [`UART_AXI_ADDR_W-1:0]  axi_araddr,
    input  logic                         axi_arvalid,
    output logic                         axi_arready,
    output logic [`UART_AXI_DATA_W-1:0]  axi_rdata,
    output logic [1:0]                   axi_rresp,
    output logic                         axi_rvalid,
    input  logic                         axi_rready,
    // UART side
    output logic [`UART_DATA_BITS-1:0]   tx_data,
    output logic                         start_tx,
    output logic                         parity_odd,
    output logic                         loopback,
    input  logic                         tx_busy,
    input  logic [`UART_DATA_BITS-1:0]   rx_data,
    input  logic                         rx_done,
    input  logic                         rx_parity_err,
    input  logic                         rx_frame_err
);

    localparam int AW = `UART_AXI_ADDR_W;
    localparam int DW = `UART_AXI_DATA_W;

    uart_pkg::reg_addr_t        wr_addr;
    uart_pkg::reg_addr_t        rd_addr;
    logic                       wr_fire;
    logic                       rd_fire;
    logic                       tx_write;
    logic                       tx_accept;
    logic                       stat_write;
    logic                       rx_read;
    logic [`UART_DATA_BITS-1:0] rx_byte;
    logic                       rx_valid;
    logic                       parity_err;
    logic                       frame_err;
    logic                       rx_overrun;
    logic                       tx_overrun;
    logic [DW-1:0]              status_word;
    logic [DW-1:0]              rd_word;

    assign wr_addr = uart_pkg::reg_addr_t'(axi_awaddr[AW-1:2]); // Word index
    assign rd_addr = uart_pkg::reg_addr_t'(axi_araddr[AW-1:2]);
    assign wr_fire = axi_awvalid & axi_awready & axi_wvalid & axi_wready;
    assign rd_fire = axi_arvalid & axi_arready;

    assign tx_write   = wr_fire && (wr_addr == uart_pkg::REG_TXDATA);
    assign tx_accept  = tx_write && !tx_busy && !start_tx; // Pending start counts busy
    assign stat_write = wr_fire && (wr_addr == uart_pkg::REG_STATUS);
    assign rx_read    = rd_fire && (rd_addr == uart_pkg::REG_RXDATA);

    assign axi_bresp = 2'b00;                  // OKAY
    assign axi_rresp = 2'b00;

    assign status_word = {{(DW-6){1'b0}}, tx_overrun, rx_overrun, frame_err,
                          parity_err, rx_valid, tx_busy | start_tx};

    // Write channel, ready pulses once when both halves are present
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            axi_awready <= 1'b0;
            axi_wready  <= 1'b0;
            axi_bvalid  <= 1'b0;
        end else begin
            axi_awready <= 1'b0;
            axi_wready  <= 1'b0;
            if (axi_awvalid && axi_wvalid && !axi_bvalid && !axi_awready) begin
                axi_awready <= 1'b1;
                axi_wready  <= 1'b1;
            end
            if (wr_fire) begin
                axi_bvalid <= 1'b1;
            end else if (axi_bvalid && axi_bready) begin
                axi_bvalid <= 1'b0;
            end
        end
    end

    // Read channel
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
        end else begin
            axi_arready <= axi_arvalid && !axi_rvalid && !axi_arready;
            if (rd_fire) begin
                axi_rvalid <= 1'b1;
            end else if (axi_rvalid && axi_rready) begin
                axi_rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (rd_addr)
            uart_pkg::REG_CTRL:   rd_word = {{(DW-2){1'b0}}, loopback, parity_odd};
            uart_pkg::REG_RXDATA: rd_word = {{(DW-`UART_DATA_BITS){1'b0}}, rx_byte};
            uart_pkg::REG_STATUS: rd_word = status_word;
            default:              rd_word = '0;  // TXDATA reads as zero
        endcase
    end

    // Read data and TX byte hold payload only
    always_ff @(posedge baud_clk) begin
        if (rd_fire) begin
            axi_rdata <= rd_word;
        end
        if (tx_accept) begin
            tx_data <= axi_wdata[`UART_DATA_BITS-1:0];
        end
    end

    // Control register, TX start and sticky flags
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            parity_odd <= 1'b0;
            loopback   <= 1'b0;
            start_tx   <= 1'b0;
            rx_byte    <= '0;
            rx_valid   <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            rx_overrun <= 1'b0;
            tx_overrun <= 1'b0;
        end else begin
            start_tx <= tx_accept;             // Single-cycle pulse
            if (wr_fire && (wr_addr == uart_pkg::REG_CTRL)) begin
                parity_odd <= axi_wdata[0];
                loopback   <= axi_wdata[1];
            end
            if (stat_write) begin              // W1C, a new event below wins
                parity_err <= parity_err & ~axi_wdata[2];
                frame_err  <= frame_err  & ~axi_wdata[3];
                rx_overrun <= rx_overrun & ~axi_wdata[4];
                tx_overrun <= tx_overrun & ~axi_wdata[5];
            end
            if (tx_write && !tx_accept) begin
                tx_overrun <= 1'b1;            // Byte dropped
            end
            if (rx_read) begin
                rx_valid <= 1'b0;
            end
            if (rx_done) begin
                rx_byte  <= rx_data;           // Overwrites unread byte
                rx_valid <= 1'b1;
                if (rx_valid && !rx_read) begin
                    rx_overrun <= 1'b1;
                end
                if (rx_parity_err) parity_err <= 1'b1;
                if (rx_frame_err) frame_err <= 1'b1;
            end
        end
    end

endmodule

// File: hw/uart_top.sv
////////////////////////////////////////////////////////////////////////////
// UART subsystem top, AXI4-Lite register access plus tx/rx pins
// Single clock; baud_clk is the bit clock, divider lives outside
// Loopback routes tx into the receiver; the rx pin is then ignored
////////////////////////////////////////////////////////////////////////////

`include "uart_config.svh"

module uart_top (
    input  logic                          baud_clk,
    input  logic                          reset,
    input  logic [`UART_AXI_ADDR_W-1:0]   axi_awaddr,
    input  logic                          axi_awvalid,
    output logic                          axi_awready,
    input  logic [`UART_AXI_DATA_W-1:0]   axi_wdata,
    input  logic [`UART_AXI_DATA_W/8-1:0] axi_wstrb,
    input  logic                          axi_wvalid,
    output logic                          axi_wready,
    output logic [1:0]                    axi_bresp,
    output logic                          axi_bvalid,
    input  logic                          axi_bready,
    input  logic [`UART_AXI_ADDR_W-1:0]   axi_araddr,
    input  logic                          axi_arvalid,
    output logic                          axi_arready,
    output logic [`UART_AXI_DATA_W-1:0]   axi_rdata,
    output logic [1:0]                    axi_rresp,
    output logic                          axi_rvalid,
    input  logic                          axi_rready,
    output logic                          tx,          // Serial out
    input  logic                          rx           // Serial in, baud_clk synchronous
);

    logic [`UART_DATA_BITS-1:0] tx_data;
    logic [`UART_DATA_BITS-1:0] rx_data;
    logic start_tx, parity_odd, loopback, tx_busy;
    logic rx_done, rx_parity_err, rx_frame_err;
    logic rx_line;                              // Receiver input after mux

    assign rx_line = loopback ? tx : rx;

    uart_regs u_regs (
        .baud_clk, .reset,
        .axi_awaddr, .axi_awvalid, .axi_awready, .axi_wdata, .axi_wstrb,
        .axi_wvalid, .axi_wready, .axi_bresp, .axi_bvalid, .axi_bready,
        .axi_araddr, .axi_arvalid, .axi_arready, .axi_rdata, .axi_rresp,
        .axi_rvalid, .axi_rready,
        .tx_data, .start_tx, .parity_odd, .loopback, .tx_busy,
        .rx_data, .rx_done, .rx_parity_err, .rx_frame_err
    );

    uart_tx u_tx (
        .baud_clk, .reset, .tx_data, .start_tx, .parity_odd, .tx, .tx_busy
    );

    uart_rx u_rx (
        .baud_clk, .reset, .rx(rx_line), .parity_odd,
        .rx_data, .rx_done, .rx_parity_err, .rx_frame_err
    );

endmodule

// File: verif/uart_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for uart_top; rx is driven synchronous to baud_clk
// Inputs change 1 ns after the rising edge and outputs are sampled there
// Every wait is a bounded loop, so a stuck DUT shows up as a timeout
////////////////////////////////////////////////////////////////////////////

`include "uart_config.svh"

module uart_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 40;               // Cycles per handshake wait
    localparam int POLLS   = 30;               // STATUS reads per poll

    logic                          baud_clk = 1'b0;
    logic                          reset;
    logic [`UART_AXI_ADDR_W-1:0]   axi_awaddr;
    logic                          axi_awvalid;
    logic                          axi_awready;
    logic [`UART_AXI_DATA_W-1:0]   axi_wdata;
    logic [`UART_AXI_DATA_W/8-1:0] axi_wstrb;
    logic                          axi_wvalid;
    logic                          axi_wready;
    logic [1:0]                    axi_bresp;
    logic                          axi_bvalid;
    logic                          axi_bready;
    logic [`UART_AXI_ADDR_W-1:0]   axi_araddr;
    logic                          axi_arvalid;
    logic                          axi_arready;
    logic [`UART_AXI_DATA_W-1:0]   axi_rdata;
    logic [1:0]                    axi_rresp;
    logic                          axi_rvalid;
    logic                          axi_rready;
    logic                          tx;
    logic                          rx;

    int     errors   = 0;
    int     timeouts = 0;
    int     checks   = 0;
    int     cyc      = 0;                      // Rising edges so far
    int     hs_cyc   = 0;                      // Edge of the last AW/W handshake
    integer seed     = 92;

    uart_top dut (.*);

    always #50 baud_clk = ~baud_clk;           // 100 ns period

    always @(posedge baud_clk) cyc <= cyc + 1;

    // Responses must hold until the master takes them
    assert property (@(posedge baud_clk) disable iff (reset)
        axi_bvalid && !axi_bready |=> axi_bvalid)
    else begin
        errors++;
        $display("bvalid dropped while bready was low");
    end

    assert property (@(posedge baud_clk) disable iff (reset)
        axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
    else begin
        errors++;
        $display("rvalid dropped or rdata changed while rready was low");
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: no %s within the allowed cycles", what);
    endtask

    // Start, data LSB first, XOR parity flipped for odd, stop
    function automatic logic [10:0] expected_frame(input logic [7:0] b, input logic odd);
        logic p;
        p = odd;
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            p = p ^ b[i];
        end
        return {1'b1, p, b, 1'b0};
    endfunction

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input bit hold_b);
        int n;
        axi_awaddr  = addr;
        axi_wdata   = data;
        axi_awvalid = 1'b1;
        axi_wvalid  = 1'b1;
        axi_bready  = !hold_b;
        n = 0;
        while (!(axi_awready && axi_wready) && n < TIMEOUT) begin
            @(posedge baud_clk);
            #1;
            n++;
        end
        if (!(axi_awready && axi_wready)) report_timeout("awready/wready");
        @(posedge baud_clk);                   // Handshake edge
        #1;
        hs_cyc      = cyc;
        axi_awvalid = 1'b0;
        axi_wvalid  = 1'b0;
        n = 0;
        while (!axi_bvalid && n < TIMEOUT) begin
            @(posedge baud_clk);
            #1;
            n++;
        end
        if (!axi_bvalid) report_timeout("bvalid");
        check_value("bresp", 32'd0, 32'(axi_bresp));
        if (hold_b) begin
            repeat (3) begin
                @(posedge baud_clk);
                #1;
                check_value("bvalid held", 32'd1, 32'(axi_bvalid));
            end
            axi_bready = 1'b1;
        end
        @(posedge baud_clk);                   // B transfer
        #1;
        axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input bit hold_r, output logic [31:0] data);
        int n;
        axi_araddr  = addr;
        axi_arvalid = 1'b1;
        axi_rready  = !hold_r;
        n = 0;
        while (!axi_arready && n < TIMEOUT) begin
            @(posedge baud_clk);
            #1;
            n++;
        end
        if (!axi_arready) report_timeout("arready");
        @(posedge baud_clk);                   // AR handshake
        #1;
        axi_arvalid = 1'b0;
        n = 0;
        while (!axi_rvalid && n < TIMEOUT) begin
            @(posedge baud_clk);
            #1;
            n++;
        end
        if (!axi_rvalid) report_timeout("rvalid");
        if (hold_r) begin
            repeat (3) begin
                @(posedge baud_clk);
                #1;
                check_value("rvalid held", 32'd1, 32'(axi_rvalid));
            end
        end
        data = axi_rdata;
        check_value("rresp", 32'd0, 32'(axi_rresp));
        axi_rready = 1'b1;
        @(posedge baud_clk);                   // R transfer
        #1;
        axi_rready = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [3:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        axi_read(addr, 1'b0, data);
        check_value(name, exp, data);
    endtask

    task automatic poll_status(input int idx, input string what, output logic [31:0] status);
        int n;
        n = 0;
        axi_read(`UART_REG_STATUS, 1'b0, status);
        while (!status[idx] && n < POLLS) begin
            axi_read(`UART_REG_STATUS, 1'b0, status);
            n++;
        end
        if (!status[idx]) report_timeout(what);
    endtask

    // Serial source for the rx pin, one bit per cycle
    task automatic drive_rx_frame(input logic [7:0] b, input logic odd,
                                  input bit bad_par, input bit bad_stop);
        logic [10:0] f;
        f     = expected_frame(b, odd);
        f[9]  = f[9] ^ bad_par;
        f[10] = !bad_stop;
        for (int i = 0; i < `UART_FRAME_BITS; i++) begin
            @(posedge baud_clk);
            #1;
            rx = f[i];
        end
        @(posedge baud_clk);
        #1;
        rx = 1'b1;                             // Back to idle
    endtask

    // Serial sink on tx, returns the 11 bits and the start edge
    task automatic capture_tx_frame(output logic [10:0] f, output int start_cyc);
        int n;
        n         = 0;
        f         = '1;
        start_cyc = -1;
        while (tx !== 1'b0 && n < TIMEOUT) begin
            @(posedge baud_clk);
            #1;
            n++;
        end
        if (tx !== 1'b0) begin
            report_timeout("start bit on tx");
        end else begin
            start_cyc = cyc;
            for (int i = 0; i < `UART_FRAME_BITS; i++) begin
                f[i] = tx;
                @(posedge baud_clk);
                #1;
            end
            check_value("tx idle after frame", 32'd1, 32'(tx));
        end
    endtask

    task automatic expect_line_idle(input int cycles);
        repeat (cycles) begin
            @(posedge baud_clk);
            #1;
            check_value("tx idle", 32'd1, 32'(tx));
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        logic [7:0]  b2;
        logic [10:0] frame;
        int          start_cyc;

        reset       = 1'b1;
        axi_awaddr  = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = '0;
        axi_wstrb   = '1;                      // Ignored by the slave
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b0;
        axi_araddr  = '0;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b0;
        rx          = 1'b1;
        repeat (16) begin
            @(posedge baud_clk);
            #1;
            check_value("tx during reset", 32'd1, 32'(tx));
        end
        reset = 1'b0;

        // Reset values
        expect_line_idle(4);
        read_expect("ctrl after reset", `UART_REG_CTRL, 32'd0);
        read_expect("status after reset", `UART_REG_STATUS, 32'd0);

        // Transmit with even then odd parity
        for (int odd = 0; odd < 2; odd++) begin
            axi_write(`UART_REG_CTRL, 32'(odd), 1'b0);
            b = 8'($random(seed));
            fork
                capture_tx_frame(frame, start_cyc);
                begin
                    axi_write(`UART_REG_TXDATA, 32'(b), 1'b0);
                    axi_read(`UART_REG_STATUS, 1'b0, rd);
                    check_value("tx_busy during frame", 32'd1, 32'(rd[0]));
                end
            join
            check_value("tx frame", 32'(expected_frame(b, 1'(odd))), 32'(frame));
            check_value("start bit edge", 32'(hs_cyc + 1), 32'(start_cyc));
            read_expect("status after frame", `UART_REG_STATUS, 32'd0);
        end

        // Loopback of random bytes
        axi_write(`UART_REG_CTRL, 32'h2, 1'b0);
        repeat (4) begin
            b = 8'($random(seed));
            axi_write(`UART_REG_TXDATA, 32'(b), 1'b0);
            poll_status(1, "rx_valid in loopback", rd);
            check_value("loopback status", 32'h2, rd);
            read_expect("loopback rxdata", `UART_REG_RXDATA, 32'(b));
            read_expect("rx_valid cleared", `UART_REG_STATUS, 32'd0);
        end

        // Bad parity, then low stop bit
        axi_write(`UART_REG_CTRL, 32'h0, 1'b0);
        b = 8'($random(seed));
        drive_rx_frame(b, 1'b0, 1'b1, 1'b0);
        poll_status(1, "rx_valid after bad parity", rd);
        check_value("parity_err status", 32'h6, rd);
        read_expect("rxdata after bad parity", `UART_REG_RXDATA, 32'(b));
        axi_write(`UART_REG_STATUS, 32'h4, 1'b0);
        read_expect("parity_err cleared", `UART_REG_STATUS, 32'd0);
        b = 8'($random(seed));
        drive_rx_frame(b, 1'b0, 1'b0, 1'b1);
        poll_status(1, "rx_valid after bad stop", rd);
        check_value("frame_err status", 32'hA, rd);
        read_expect("rxdata after bad stop", `UART_REG_RXDATA, 32'(b));
        axi_write(`UART_REG_STATUS, 32'h8, 1'b0);
        read_expect("frame_err cleared", `UART_REG_STATUS, 32'd0);

        // RX overrun, two bytes with no read between
        b  = 8'($random(seed));
        b2 = 8'($random(seed));
        drive_rx_frame(b, 1'b0, 1'b0, 1'b0);
        drive_rx_frame(b2, 1'b0, 1'b0, 1'b0);
        poll_status(4, "rx_overrun", rd);
        check_value("rx_overrun status", 32'h12, rd);
        read_expect("rxdata keeps second byte", `UART_REG_RXDATA, 32'(b2));
        axi_write(`UART_REG_STATUS, 32'h10, 1'b0);
        read_expect("rx_overrun cleared", `UART_REG_STATUS, 32'd0);

        // TX overrun, second write lands mid-frame
        b  = 8'($random(seed));
        b2 = 8'($random(seed));
        fork
            capture_tx_frame(frame, start_cyc);
            begin
                axi_write(`UART_REG_TXDATA, 32'(b), 1'b0);
                axi_write(`UART_REG_TXDATA, 32'(b2), 1'b0);
            end
        join
        check_value("tx frame under overrun", 32'(expected_frame(b, 1'b0)), 32'(frame));
        expect_line_idle(16);                  // Dropped byte never sent
        read_expect("tx_overrun status", `UART_REG_STATUS, 32'h20);
        axi_write(`UART_REG_STATUS, 32'h20, 1'b0);
        read_expect("tx_overrun cleared", `UART_REG_STATUS, 32'd0);

        // Back-pressure on B and R
        axi_write(`UART_REG_CTRL, 32'h1, 1'b1);
        axi_read(`UART_REG_CTRL, 1'b1, rd);
        check_value("ctrl under back-pressure", 32'h1, rd);

        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_top.sv
verif/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = uart_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The pipeline status is the status of grep, so a missing pass line fails
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "TEST OK" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
